//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_pixel_sequencer
FLIST     := flist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- char_shifter.sv
`default_nettype none

`include "vic_config.svh"

module char_shifter import vic_pkg::*; (
    input  wire               clk_dot4x,
    input  wire               rst,
    input  wire               dot_rising_0_i,
    input  wire               phase_start_12_i,
    input  wire               phase_start_15_i,
    input  wire               clk_phi_i,
    input  wire  [2:0]        xpos_mod_8_i,
    input  wire  [6:0]        cycle_num_i,
    input  wire  vic_regs_t   regs_i,
    input  wire  char_fetch_t fetch_i,
    output shift_state_t      shift_o
);

    char_fetch_t fetch_dly;
    logic [2:0]  xscroll_dly;
    logic        shift_toggle;
    logic [7:0]  pixels_shifting;
    logic [11:0] char_shifting;
    logic        is_background;
    logic        mcm;
    logic        bmm;
    logic        ecm;
    logic        ismc;
    logic        load_pixels;
    logic        vis_cycle;

    assign mcm = regs_i.mode[0];
    assign bmm = regs_i.mode[1];
    assign ecm = regs_i.mode[2];

    assign ismc        = mcm & (bmm | ecm | char_shifting[11]);
    assign load_pixels = (xpos_mod_8_i == xscroll_dly);
    assign vis_cycle   = (cycle_num_i >= `VIS_CYCLE_FIRST) && (cycle_num_i <= `VIS_CYCLE_LAST);

    // fetch data and xscroll are taken late in the low phi half
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            fetch_dly   <= '0;
            xscroll_dly <= 3'd0;
        end else if (!clk_phi_i) begin
            if (phase_start_12_i) begin
                fetch_dly <= fetch_i;
            end
            if (phase_start_15_i && vis_cycle) begin
                xscroll_dly <= regs_i.xscroll;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_toggle    <= 1'b0;
            pixels_shifting <= 8'd0;
            char_shifting   <= 12'd0;
            is_background   <= 1'b0;
        end else if (dot_rising_0_i) begin
            if (load_pixels) begin
                // multicolour waits a dot before its first pair shift
                shift_toggle    <= ~(mcm & (bmm | ecm | fetch_dly.char_word[11]));
                pixels_shifting <= fetch_dly.pixels;
                char_shifting   <= fetch_dly.char_word;
                is_background   <= ~fetch_dly.pixels[7];
            end else begin
                if (ismc) begin
                    shift_toggle <= ~shift_toggle;
                end
                if (shift_toggle) begin
                    if (ismc) begin
                        pixels_shifting <= {pixels_shifting[5:0], 2'b00};
                        is_background   <= ~pixels_shifting[5];
                    end else begin
                        pixels_shifting <= {pixels_shifting[6:0], 1'b0};
                        is_background   <= ~pixels_shifting[6];
                    end
                end
            end
        end
    end

    assign shift_o = '{
        pixels_shifting: pixels_shifting,
        char_shifting:   char_shifting,
        ismc:            ismc,
        is_background:   is_background
    };

    a_shift_on_dot: assert property (@(posedge clk_dot4x) disable iff (rst)
        !dot_rising_0_i |=> $stable({pixels_shifting, char_shifting, shift_toggle}));

endmodule

`default_nettype wire

//--- dot_timing.sv
`default_nettype none

module dot_timing (
    input  wire        clk_dot4x,
    input  wire        rst,
    output logic       dot_rising_0_o,
    output logic       phase_start_12_o,
    output logic       phase_start_15_o,
    output logic       clk_phi_o,
    output logic [2:0] xpos_mod_8_o,
    output logic [6:0] cycle_num_o
);

    logic [1:0] tick_cnt;
    logic [3:0] phase_cnt;

    // strobes are registered, so each compares one count early
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            tick_cnt         <= 2'd0;
            phase_cnt        <= 4'd0;
            dot_rising_0_o   <= 1'b0;
            phase_start_12_o <= 1'b0;
            phase_start_15_o <= 1'b0;
            clk_phi_o        <= 1'b0;
            xpos_mod_8_o     <= 3'd0;
            cycle_num_o      <= 7'd0;
        end else begin
            tick_cnt         <= tick_cnt + 2'd1;
            phase_cnt        <= phase_cnt + 4'd1;
            dot_rising_0_o   <= (tick_cnt == 2'd0);
            phase_start_12_o <= (phase_cnt == 4'd11);
            phase_start_15_o <= (phase_cnt == 4'd14);
            // phi half ends when the phase counter wraps
            if (phase_cnt == 4'd15) begin
                clk_phi_o <= ~clk_phi_o;
                if (!clk_phi_o) begin
                    cycle_num_o <= (cycle_num_o == 7'd62) ? 7'd0 : cycle_num_o + 7'd1;
                end
            end
            if (dot_rising_0_o) begin
                xpos_mod_8_o <= xpos_mod_8_o + 3'd1;
            end
        end
    end

    a_dot_single: assert property (@(posedge clk_dot4x) disable iff (rst)
        dot_rising_0_o |=> !dot_rising_0_o);

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
vic_pkg.sv
dot_timing.sv
char_shifter.sv
mode_colorizer.sv
sprite_border_mux.sv
pixel_sequencer_top.sv
tb_clock_gen.sv
tb_pixel_sequencer.sv

//--- mode_colorizer.sv
`default_nettype none

`include "vic_config.svh"

module mode_colorizer import vic_pkg::*; (
    input  wire                clk_dot4x,
    input  wire                rst,
    input  wire                dot_rising_0_i,
    input  wire  vic_regs_t    regs_i,
    input  wire  shift_state_t shift_i,
    output color_stage_t       color_o
);

    logic [1:0]  pair;
    logic [11:0] chr;
    logic [3:0]  next_color;

    // pair 11 colour differs between the valid and invalid mc char modes
    function automatic logic [3:0] mc_char_color(
        input logic [1:0] sel,
        input logic [3:0] c11,
        input vic_regs_t  r
    );
        case (sel)
            2'b00:   return r.b0c;
            2'b01:   return r.b1c;
            2'b10:   return r.b2c;
            default: return c11;
        endcase
    endfunction

    // extended background, char bits 7:6 pick the background register
    function automatic logic [3:0] ecm_color(
        input logic       pix,
        input logic [1:0] sel,
        input logic [3:0] fore,
        input vic_regs_t  r
    );
        if (pix) begin
            return fore;
        end
        case (sel)
            2'b00:   return r.b0c;
            2'b01:   return r.b1c;
            2'b10:   return r.b2c;
            default: return r.b3c;
        endcase
    endfunction

    assign pair = shift_i.pixels_shifting[7:6];
    assign chr  = shift_i.char_shifting;

    always_comb begin
        next_color = `COLOR_BLACK;
        case (regs_i.mode)
            MODE_STD_CHAR: begin
                next_color = pair[1] ? chr[11:8] : regs_i.b0c;
            end
            MODE_MC_CHAR: begin
                // ismc here reduces to char bit 11
                if (shift_i.ismc) begin
                    next_color = mc_char_color(pair, {1'b0, chr[10:8]}, regs_i);
                end else begin
                    next_color = pair[1] ? chr[11:8] : regs_i.b0c;
                end
            end
            MODE_STD_BITMAP, MODE_INV_STD_BITMAP: begin
                next_color = pair[1] ? chr[7:4] : chr[3:0];
            end
            MODE_MC_BITMAP, MODE_INV_MC_BITMAP: begin
                case (pair)
                    2'b00:   next_color = regs_i.b0c;
                    2'b01:   next_color = chr[7:4];
                    2'b10:   next_color = chr[3:0];
                    default: next_color = chr[11:8];
                endcase
            end
            MODE_ECM_CHAR: begin
                next_color = ecm_color(pair[1], chr[7:6], chr[11:8], regs_i);
            end
            MODE_INV_MC_CHAR: begin
                if (chr[11]) begin
                    next_color = mc_char_color(pair, chr[11:8], regs_i);
                end else begin
                    next_color = ecm_color(pair[1], chr[7:6], chr[11:8], regs_i);
                end
            end
        endcase
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            color_o <= '{color: `COLOR_BLACK, is_background: 1'b0};
        end else if (dot_rising_0_i) begin
            color_o <= '{color: next_color, is_background: shift_i.is_background};
        end
    end

endmodule

`default_nettype wire

//--- pixel_sequencer_top.sv
`default_nettype none

module pixel_sequencer_top import vic_pkg::*; (
    input  wire               clk_dot4x,
    input  wire               rst,
    input  wire  vic_regs_t   regs_i,
    input  wire  char_fetch_t fetch_i,
    input  wire  sprite_bus_t sprites_i,
    input  wire               main_border_i,
    output logic [3:0]        pixel_color_o,
    output logic              is_background_o,
    output logic              dot_strobe_o
);

    logic         phase_start_12;
    logic         phase_start_15;
    logic         clk_phi;
    logic [2:0]   xpos_mod_8;
    logic [6:0]   cycle_num;
    shift_state_t shift_state;
    color_stage_t color_stage;

    // the dot strobe port doubles as the internal dot strobe
    dot_timing i_dot_timing (
        .clk_dot4x        (clk_dot4x),
        .rst              (rst),
        .dot_rising_0_o   (dot_strobe_o),
        .phase_start_12_o (phase_start_12),
        .phase_start_15_o (phase_start_15),
        .clk_phi_o        (clk_phi),
        .xpos_mod_8_o     (xpos_mod_8),
        .cycle_num_o      (cycle_num)
    );

    char_shifter i_char_shifter (
        .clk_dot4x        (clk_dot4x),
        .rst              (rst),
        .dot_rising_0_i   (dot_strobe_o),
        .phase_start_12_i (phase_start_12),
        .phase_start_15_i (phase_start_15),
        .clk_phi_i        (clk_phi),
        .xpos_mod_8_i     (xpos_mod_8),
        .cycle_num_i      (cycle_num),
        .regs_i           (regs_i),
        .fetch_i          (fetch_i),
        .shift_o          (shift_state)
    );

    mode_colorizer i_mode_colorizer (
        .clk_dot4x      (clk_dot4x),
        .rst            (rst),
        .dot_rising_0_i (dot_strobe_o),
        .regs_i         (regs_i),
        .shift_i        (shift_state),
        .color_o        (color_stage)
    );

    sprite_border_mux i_sprite_border_mux (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .dot_rising_0_i  (dot_strobe_o),
        .regs_i          (regs_i),
        .sprites_i       (sprites_i),
        .main_border_i   (main_border_i),
        .color_i         (color_stage),
        .pixel_color_o   (pixel_color_o),
        .is_background_o (is_background_o)
    );

endmodule

`default_nettype wire

//--- sprite_border_mux.sv
`default_nettype none

`include "vic_config.svh"

module sprite_border_mux import vic_pkg::*; (
    input  wire                clk_dot4x,
    input  wire                rst,
    input  wire                dot_rising_0_i,
    input  wire  vic_regs_t    regs_i,
    input  wire  sprite_bus_t  sprites_i,
    input  wire                main_border_i,
    input  wire  color_stage_t color_i,
    output logic [3:0]         pixel_color_o,
    output logic               is_background_o
);

    logic [`NUM_SPRITES-1:0][1:0] sprite_dly;
    logic                         is_invalid;
    logic [3:0]                   base_color;
    logic [3:0]                   mixed_color;

    // align sprite pixels with the colour stage
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            sprite_dly <= '0;
        end else if (dot_rising_0_i) begin
            sprite_dly <= sprites_i.cur_pixel;
        end
    end

    assign is_invalid = regs_i.mode inside {MODE_INV_MC_CHAR, MODE_INV_STD_BITMAP,
                                            MODE_INV_MC_BITMAP};
    assign base_color = is_invalid ? `COLOR_BLACK : color_i.color;

    // walk from the highest sprite down so sprite 0 ends on top
    always_comb begin
        mixed_color = base_color;
        for (int n = `NUM_SPRITES - 1; n >= 0; n--) begin
            if (!sprites_i.pri[n] || color_i.is_background) begin
                if (sprites_i.mmc[n]) begin
                    case (sprite_dly[n])
                        2'b01:   mixed_color = sprites_i.mc0;
                        2'b10:   mixed_color = sprites_i.col[n];
                        2'b11:   mixed_color = sprites_i.mc1;
                        default: ;
                    endcase
                end else if (sprite_dly[n][1]) begin
                    mixed_color = sprites_i.col[n];
                end
            end
            // a behind-foreground sprite undoes lower sprites drawn over it
            if (sprites_i.pri[n] && !color_i.is_background && sprite_dly[n][1]) begin
                mixed_color = base_color;
            end
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pixel_color_o   <= `COLOR_BLACK;
            is_background_o <= 1'b0;
        end else begin
            pixel_color_o   <= main_border_i ? regs_i.ec : mixed_color;
            is_background_o <= color_i.is_background;
        end
    end

    a_border_ec: assert property (@(posedge clk_dot4x) disable iff (rst)
        main_border_i |=> (pixel_color_o == $past(regs_i.ec)));

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release on a falling edge, like every other DUT input
    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_pixel_sequencer.sv
`default_nettype none

`include "vic_config.svh"

module tb_pixel_sequencer import vic_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETTLE_PHI   = 40;
    localparam int CHECK_PHI    = 8;
    localparam int DOTS_PER_PHI = 8;
    localparam int NUM_RUNS     = 23;
    localparam int PHI_NS       = 3200;
    // one extra phi per run for the hand-over sample, plus margin for reset
    localparam int WATCHDOG_NS  = (NUM_RUNS * (SETTLE_PHI + CHECK_PHI + 1) + 20) * PHI_NS;

    logic        clk_dot4x;
    logic        rst;
    vic_regs_t   regs_i;
    char_fetch_t fetch_i;
    sprite_bus_t sprites_i;
    logic        main_border_i;
    logic [3:0]  pixel_color_o;
    logic        is_background_o;
    logic        dot_strobe_o;

    int    seed        = 32'hef5f;
    bit    check_en;
    string test_name;
    event  sample_ev;

    tb_clock_gen #(
        .PERIOD_NS    (100),
        .RESET_CYCLES (10)
    ) i_clock_gen (
        .clk_o (clk_dot4x),
        .rst_o (rst)
    );

    pixel_sequencer_top i_dut (
        .clk_dot4x       (clk_dot4x),
        .rst             (rst),
        .regs_i          (regs_i),
        .fetch_i         (fetch_i),
        .sprites_i       (sprites_i),
        .main_border_i   (main_border_i),
        .pixel_color_o   (pixel_color_o),
        .is_background_o (is_background_o),
        .dot_strobe_o    (dot_strobe_o)
    );

    // expected colour and background flag at shifter position pos (0..7)
    function automatic color_stage_t ref_pixel(
        input vic_regs_t   r,
        input char_fetch_t f,
        input sprite_bus_t s,
        input logic        border,
        input int          pos
    );
        logic       mc;
        logic [1:0] bits;
        logic [1:0] sp;
        logic [3:0] base;
        logic [3:0] col;
        logic       bg;
        int         idx;
        mc = r.mode[0] && (r.mode[1] || r.mode[2] || f.char_word[11]);
        if (mc) begin
            idx  = 7 - 2 * (pos / 2);
            bits = {f.pixels[idx], f.pixels[idx - 1]};
        end else begin
            bits = {f.pixels[7 - pos], 1'b0};
        end
        bg = ~bits[1];
        case (r.mode)
            MODE_STD_CHAR:   base = bits[1] ? f.char_word[11:8] : r.b0c;
            MODE_MC_CHAR: begin
                if (!f.char_word[11]) begin
                    base = bits[1] ? f.char_word[11:8] : r.b0c;
                end else if (bits == 2'b00) begin
                    base = r.b0c;
                end else if (bits == 2'b01) begin
                    base = r.b1c;
                end else if (bits == 2'b10) begin
                    base = r.b2c;
                end else begin
                    base = {1'b0, f.char_word[10:8]};
                end
            end
            MODE_STD_BITMAP: base = bits[1] ? f.char_word[7:4] : f.char_word[3:0];
            MODE_MC_BITMAP: begin
                case (bits)
                    2'b00:   base = r.b0c;
                    2'b01:   base = f.char_word[7:4];
                    2'b10:   base = f.char_word[3:0];
                    default: base = f.char_word[11:8];
                endcase
            end
            MODE_ECM_CHAR: begin
                case ({bits[1], f.char_word[7:6]})
                    3'b000:  base = r.b0c;
                    3'b001:  base = r.b1c;
                    3'b010:  base = r.b2c;
                    3'b011:  base = r.b3c;
                    default: base = f.char_word[11:8];
                endcase
            end
            default:         base = `COLOR_BLACK;
        endcase
        col = base;
        // lowest sprite last so it ends on top
        for (int n = `NUM_SPRITES - 1; n >= 0; n--) begin
            sp = s.cur_pixel[n];
            if (s.pri[n] && !bg) begin
                if (sp[1]) begin
                    col = base;
                end
            end else if (s.mmc[n]) begin
                if (sp == 2'b01) begin
                    col = s.mc0;
                end else if (sp == 2'b10) begin
                    col = s.col[n];
                end else if (sp == 2'b11) begin
                    col = s.mc1;
                end
            end else if (sp[1]) begin
                col = s.col[n];
            end
        end
        if (border) begin
            col = r.ec;
        end
        return '{color: col, is_background: bg};
    endfunction

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_color(input string name, input int dot,
                               input logic [3:0] exp_color, input logic [3:0] act_color);
        if (act_color !== exp_color) begin
            $display("Mismatch %s pixel_color_o at dot %0d: expected %h, actual %h",
                     name, dot, exp_color, act_color);
            abort_run();
        end
    endtask

    task automatic check_background(input string name, input int dot,
                                    input logic exp_bg, input logic act_bg);
        if (act_bg !== exp_bg) begin
            $display("Mismatch %s is_background_o at dot %0d: expected %b, actual %b",
                     name, dot, exp_bg, act_bg);
            abort_run();
        end
    endtask

    task automatic wait_dot();
        @(negedge clk_dot4x);
        while (dot_strobe_o !== 1'b1) begin
            @(negedge clk_dot4x);
        end
    endtask

    task automatic rand_regs(input video_mode_e mode, output vic_regs_t r);
        logic [31:0] rnd;
        rnd       = $random(seed);
        r.mode    = mode;
        r.b0c     = rnd[3:0];
        r.b1c     = rnd[7:4];
        r.b2c     = rnd[11:8];
        r.b3c     = rnd[15:12];
        r.ec      = rnd[19:16];
        r.xscroll = rnd[22:20];
    endtask

    task automatic rand_fetch(output char_fetch_t f);
        logic [31:0] rnd;
        rnd         = $random(seed);
        f.pixels    = rnd[7:0];
        f.char_word = rnd[19:8];
    endtask

    task automatic rand_sprites(input logic multicolor, output sprite_bus_t s);
        logic [31:0] rnd;
        rnd         = $random(seed);
        s.mmc       = {`NUM_SPRITES{multicolor}};
        s.cur_pixel = rnd[15:0];
        s.pri       = rnd[23:16];
        s.mc0       = rnd[27:24];
        s.mc1       = rnd[31:28];
        rnd         = $random(seed);
        s.col       = rnd;
    endtask

    // inputs change right after a sample, which is a falling edge
    task automatic run_test(input string name, input vic_regs_t r, input char_fetch_t f,
                            input sprite_bus_t s, input logic border);
        @(sample_ev);
        check_en      = 1'b0;
        test_name     = name;
        regs_i        = r;
        fetch_i       = f;
        sprites_i     = s;
        main_border_i = border;
        repeat (SETTLE_PHI * DOTS_PER_PHI) @(sample_ev);
        check_en = 1'b1;
        repeat (CHECK_PHI * DOTS_PER_PHI) @(sample_ev);
    endtask

    initial begin : compare_samples
        color_stage_t expected;
        int           dot_index;
        int           dot;
        int           pos;
        dot_index = 0;
        forever begin
            wait_dot();
            dot = dot_index;
            dot_index++;
            @(negedge clk_dot4x);
            @(negedge clk_dot4x);
            if (check_en) begin
                // output now shows the shift state left by the previous strobe
                pos      = (dot + 7 - int'(regs_i.xscroll)) % 8;
                expected = ref_pixel(regs_i, fetch_i, sprites_i, main_border_i, pos);
                check_color(test_name, dot, expected.color, pixel_color_o);
                check_background(test_name, dot, expected.is_background, is_background_o);
            end
            -> sample_ev;
        end
    end

    // one clock high in every four once the first strobe has come
    initial begin : strobe_spacing
        int since_strobe;
        since_strobe = -1;
        forever begin
            @(negedge clk_dot4x);
            if (dot_strobe_o === 1'b1) begin
                if (since_strobe >= 0 && since_strobe != 3) begin
                    $display("dot strobe came %0d clocks after the previous one",
                             since_strobe + 1);
                    abort_run();
                end
                since_strobe = 0;
            end else if (since_strobe >= 0) begin
                since_strobe++;
                if (since_strobe > 3) begin
                    $display("dot strobe missing four clocks after the previous one");
                    abort_run();
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired before all tests finished");
        abort_run();
    end

    initial begin : stimulus
        vic_regs_t   r;
        char_fetch_t f;
        sprite_bus_t s;
        check_en      = 1'b0;
        test_name     = "idle";
        regs_i        = '0;
        fetch_i       = '0;
        sprites_i     = '0;
        main_border_i = 1'b0;

        // standard char and bitmap
        s = '0;
        for (int i = 0; i < 2; i++) begin
            rand_regs(MODE_STD_CHAR, r);
            rand_fetch(f);
            run_test("std_char", r, f, s, 1'b0);
            rand_regs(MODE_STD_BITMAP, r);
            rand_fetch(f);
            run_test("std_bitmap", r, f, s, 1'b0);
        end

        // multicolour char and bitmap
        rand_regs(MODE_MC_CHAR, r);
        rand_fetch(f);
        f.char_word[11] = 1'b1;
        run_test("mc_char", r, f, s, 1'b0);
        rand_regs(MODE_MC_CHAR, r);
        rand_fetch(f);
        f.char_word[11] = 1'b0;
        run_test("mc_char_hires", r, f, s, 1'b0);
        for (int i = 0; i < 2; i++) begin
            rand_regs(MODE_MC_BITMAP, r);
            rand_fetch(f);
            run_test("mc_bitmap", r, f, s, 1'b0);
        end

        // extended colour and the invalid codes
        for (int i = 0; i < 2; i++) begin
            rand_regs(MODE_ECM_CHAR, r);
            rand_fetch(f);
            run_test("ecm_char", r, f, s, 1'b0);
        end
        rand_regs(MODE_INV_MC_CHAR, r);
        rand_fetch(f);
        run_test("inv_mc_char", r, f, s, 1'b0);
        rand_regs(MODE_INV_STD_BITMAP, r);
        rand_fetch(f);
        run_test("inv_std_bitmap", r, f, s, 1'b0);
        rand_regs(MODE_INV_MC_BITMAP, r);
        rand_fetch(f);
        run_test("inv_mc_bitmap", r, f, s, 1'b0);

        // hires sprites with mixed priority
        rand_regs(MODE_STD_CHAR, r);
        rand_fetch(f);
        rand_sprites(1'b0, s);
        run_test("sprite_pri_std_char", r, f, s, 1'b0);
        rand_regs(MODE_MC_BITMAP, r);
        rand_fetch(f);
        rand_sprites(1'b0, s);
        run_test("sprite_pri_mc_bitmap", r, f, s, 1'b0);
        rand_regs(MODE_ECM_CHAR, r);
        rand_fetch(f);
        rand_sprites(1'b0, s);
        run_test("sprite_pri_ecm", r, f, s, 1'b0);
        rand_regs(MODE_INV_STD_BITMAP, r);
        rand_fetch(f);
        rand_sprites(1'b0, s);
        run_test("sprite_pri_invalid", r, f, s, 1'b0);

        // multicolour sprites
        rand_regs(MODE_STD_CHAR, r);
        rand_fetch(f);
        rand_sprites(1'b1, s);
        run_test("sprite_mc_std_char", r, f, s, 1'b0);
        rand_regs(MODE_STD_BITMAP, r);
        rand_fetch(f);
        rand_sprites(1'b1, s);
        run_test("sprite_mc_std_bitmap", r, f, s, 1'b0);
        rand_regs(MODE_MC_CHAR, r);
        rand_fetch(f);
        rand_sprites(1'b1, s);
        run_test("sprite_mc_mc_char", r, f, s, 1'b0);

        // border on top of everything
        rand_regs(MODE_MC_BITMAP, r);
        rand_fetch(f);
        rand_sprites(1'b1, s);
        run_test("border_mc_bitmap", r, f, s, 1'b1);
        rand_regs(MODE_STD_CHAR, r);
        rand_fetch(f);
        rand_sprites(1'b0, s);
        run_test("border_std_char", r, f, s, 1'b1);
        rand_regs(MODE_INV_MC_CHAR, r);
        rand_fetch(f);
        rand_sprites(1'b1, s);
        run_test("border_invalid", r, f, s, 1'b1);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vic_config.svh
`ifndef VIC_CONFIG_SVH
`define VIC_CONFIG_SVH

// sprites overlaid on the character/bitmap layer
`define NUM_SPRITES 8

// colour index used for illegal modes and after reset
`define COLOR_BLACK 4'd0

// cycles in which a new xscroll value is picked up
`define VIS_CYCLE_FIRST 7'd15
`define VIS_CYCLE_LAST 7'd55

`endif

//--- vic_pkg.sv
`default_nettype none

`include "vic_config.svh"

package vic_pkg;

    // {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        MODE_STD_CHAR       = 3'b000,
        MODE_MC_CHAR        = 3'b001,
        MODE_STD_BITMAP     = 3'b010,
        MODE_MC_BITMAP      = 3'b011,
        MODE_ECM_CHAR       = 3'b100,
        MODE_INV_MC_CHAR    = 3'b101,
        MODE_INV_STD_BITMAP = 3'b110,
        MODE_INV_MC_BITMAP  = 3'b111
    } video_mode_e;

    typedef struct packed {
        video_mode_e mode;
        logic [3:0]  b0c;
        logic [3:0]  b1c;
        logic [3:0]  b2c;
        logic [3:0]  b3c;
        logic [3:0]  ec;
        logic [2:0]  xscroll;
    } vic_regs_t;

    typedef struct packed {
        logic [7:0]  pixels;
        logic [11:0] char_word;
    } char_fetch_t;

    // index n of each array belongs to sprite n
    typedef struct packed {
        logic [`NUM_SPRITES-1:0][1:0] cur_pixel;
        logic [`NUM_SPRITES-1:0][3:0] col;
        logic [`NUM_SPRITES-1:0]      pri;
        logic [`NUM_SPRITES-1:0]      mmc;
        logic [3:0]                   mc0;
        logic [3:0]                   mc1;
    } sprite_bus_t;

    typedef struct packed {
        logic [7:0]  pixels_shifting;
        logic [11:0] char_shifting;
        logic        ismc;
        logic        is_background;
    } shift_state_t;

    typedef struct packed {
        logic [3:0] color;
        logic       is_background;
    } color_stage_t;

endpackage

`default_nettype wire
